// ==== cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Address geometry
`define CACHE_ADDR_W 12
`define CACHE_TAG_W 6
`define CACHE_INDEX_W 4
`define CACHE_SETS 16
`define CACHE_OFFSET_W 2

// Line geometry
`define CACHE_WORDS 4
`define CACHE_DATA_W 32
`define CACHE_LINE_W (`CACHE_DATA_W * `CACHE_WORDS)

`endif

// ==== cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

	typedef enum logic [1:0] {
		opRead = 2'd0,
		opWrite = 2'd1,
		opInvalidate = 2'd2 // Code 3 unused
	} cacheOp_t;

	typedef enum logic [2:0] {
		stIdle,
		stLookup,
		stFlushReq,
		stFlushWait,
		stFillReq,
		stFillWait,
		stUpdate,
		stDone
	} ctrlState_t;

	typedef logic [`CACHE_WORDS-1:0][`CACHE_DATA_W-1:0] line_t;

	typedef logic way_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		logic [`CACHE_TAG_W-1:0] tag;
	} lineStatus_t;

endpackage

// ==== tagLookup_if.sv ====
`timescale 1ns/100ps
`include "cache_macros.svh"

interface tagLookup_if import cache_pkg::*; ();
	// Request and update, from controller
	logic [`CACHE_INDEX_W-1:0] index;
	logic [`CACHE_TAG_W-1:0] tag;
	logic update;
	way_t setWay;
	logic setValid;
	logic setDirty;
	logic touch;

	// Lookup results, from tag store
	logic hitAny;
	way_t hitWay;
	way_t victimWay;
	logic victimDirty;
	logic [`CACHE_TAG_W-1:0] victimTag;

	modport ctrl(output index, tag, update, setWay, setValid, setDirty, touch,
		input hitAny, hitWay, victimWay, victimDirty, victimTag);

	modport store(input index, tag, update, setWay, setValid, setDirty, touch,
		output hitAny, hitWay, victimWay, victimDirty, victimTag);

endinterface

// ==== tagStore.sv ====
`timescale 1ns/100ps
`include "cache_macros.svh"

module tagStore import cache_pkg::*; (
	input logic clk,
	input logic reset,
	tagLookup_if.store lookup
);

	lineStatus_t status [2][`CACHE_SETS];
	logic [`CACHE_SETS-1:0] lru; // Way to replace next, per set
	logic [1:0] wayHit;
	lineStatus_t victim;

	// Lookup --------------------

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			wayHit[w] = status[w][lookup.index].valid &&
				(status[w][lookup.index].tag == lookup.tag);
		end
	end

	assign lookup.hitAny = |wayHit;
	assign lookup.hitWay = way_t'(wayHit[1]);

	// Hit way on a hit, else the LRU way
	assign lookup.victimWay = lookup.hitAny ? lookup.hitWay : way_t'(lru[lookup.index]);

	assign victim = status[lookup.victimWay][lookup.index];
	assign lookup.victimDirty = victim.valid && victim.dirty;
	assign lookup.victimTag = victim.tag;

	// Update --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			lru <= '0;
			for (int s = 0; s < `CACHE_SETS; s++) begin
				for (int w = 0; w < 2; w++) begin
					status[w][s].valid <= 1'b0;
					status[w][s].dirty <= 1'b0;
				end
			end
		end else begin
			if (lookup.update) begin
				status[lookup.setWay][lookup.index] <= '{
					valid: lookup.setValid,
					dirty: lookup.setDirty,
					tag: lookup.tag
				};
			end
			if (lookup.touch) begin
				lru[lookup.index] <= ~lookup.setWay; // Other way becomes LRU
			end
		end
	end

endmodule

// ==== dataStore.sv ====
`timescale 1ns/100ps
`include "cache_macros.svh"

module dataStore import cache_pkg::*; (
	input logic clk,
	input logic [`CACHE_INDEX_W-1:0] index,
	input way_t way,
	input logic [`CACHE_OFFSET_W-1:0] wordSel,
	input logic wordWe,
	input logic [`CACHE_DATA_W-1:0] wordIn,
	input logic lineWe,
	input line_t lineIn,
	output logic [`CACHE_DATA_W-1:0] wordOut,
	output line_t lineOut
);

	line_t data [2][`CACHE_SETS];

	// Addressed line, also the writeback source
	assign lineOut = data[way][index];
	assign wordOut = lineOut[wordSel];

	always_ff @(posedge clk) begin
		if (lineWe) begin
			data[way][index] <= lineIn; // Fill from memory
		end else if (wordWe) begin
			data[way][index][wordSel] <= wordIn;
		end
	end

endmodule

// ==== cacheController.sv ====
`timescale 1ns/100ps
`include "cache_macros.svh"

module cacheController import cache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic req,
	input cacheOp_t op,
	input logic [`CACHE_ADDR_W-1:0] addr,
	input logic [`CACHE_DATA_W-1:0] wrData,
	output logic ack,
	output logic hit,
	tagLookup_if.ctrl lookup,
	output way_t dataWay,
	output logic wordWe,
	output logic lineWe,
	output line_t lineIn,
	input line_t lineOut,
	output logic memRdReq,
	output logic [`CACHE_ADDR_W-1:0] memRdAddr,
	input logic memRdAck,
	input line_t memRdData,
	output logic memWrReq,
	output logic [`CACHE_ADDR_W-1:0] memWrAddr,
	output line_t memWrData,
	input logic memWrAck
);

	ctrlState_t state;
	ctrlState_t nextState;
	logic [`CACHE_TAG_W-1:0] reqTag;
	logic [`CACHE_INDEX_W-1:0] reqIndex;
	logic isWrite;
	logic isInval;

	assign reqTag = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign reqIndex = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign isWrite = (op == opWrite);
	assign isInval = (op == opInvalidate);

	// Tag store side --------------------

	assign lookup.index = reqIndex;
	assign lookup.tag = reqTag;
	assign lookup.setWay = dataWay;
	assign lookup.setValid = !isInval;
	assign lookup.setDirty = isWrite;
	// Read hit only moves the LRU bit
	assign lookup.update = (state == stUpdate) && (!hit || isWrite || isInval);
	assign lookup.touch = (state == stUpdate) && !isInval;

	// Data store and memory side --------------------

	assign wordWe = (state == stUpdate) && isWrite;
	assign lineWe = (state == stFillWait) && memRdReq && memRdAck;
	assign lineIn = memRdData;
	assign memWrData = lineOut; // Victim line, stable while memWrReq high
	assign ack = (state == stDone);

	always_comb begin
		nextState = state;
		case (state)
			stIdle: begin
				if (req) nextState = stLookup;
			end
			stLookup: begin
				if (isInval && !lookup.hitAny) begin
					nextState = stDone; // Nothing to invalidate
				end else if (lookup.hitAny && !(isInval && lookup.victimDirty)) begin
					nextState = stUpdate;
				end else if (lookup.victimDirty) begin
					nextState = stFlushReq;
				end else begin
					nextState = stFillReq;
				end
			end
			stFlushReq: nextState = stFlushWait;
			stFlushWait: begin
				if (!memWrReq && !memWrAck) nextState = isInval ? stUpdate : stFillReq;
			end
			stFillReq: nextState = stFillWait;
			stFillWait: begin
				if (!memRdReq && !memRdAck) nextState = stUpdate;
			end
			stUpdate: nextState = stDone;
			stDone: begin
				if (!req) nextState = stIdle;
			end
			default: nextState = stIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
			hit <= 1'b0;
			memRdReq <= 1'b0;
			memWrReq <= 1'b0;
		end else begin
			state <= nextState;
			if (state == stLookup) hit <= lookup.hitAny;
			if (state == stFlushReq) begin
				memWrReq <= 1'b1;
			end else if (state == stFlushWait && memWrAck) begin
				memWrReq <= 1'b0;
			end
			if (state == stFillReq) begin
				memRdReq <= 1'b1;
			end else if (state == stFillWait && memRdAck) begin
				memRdReq <= 1'b0;
			end
		end
	end

	// Way and line addresses held for the whole request
	always_ff @(posedge clk) begin
		if (state == stLookup) begin
			dataWay <= lookup.victimWay;
			memRdAddr <= {reqTag, reqIndex, {`CACHE_OFFSET_W{1'b0}}};
			memWrAddr <= {lookup.victimTag, reqIndex, {`CACHE_OFFSET_W{1'b0}}};
		end
	end

endmodule

// ==== cacheTop.sv ====
`timescale 1ns/100ps
`include "cache_macros.svh"

module cacheTop import cache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic req,
	input cacheOp_t op,
	input logic [`CACHE_ADDR_W-1:0] addr,
	input logic [`CACHE_DATA_W-1:0] wrData,
	output logic ack,
	output logic [`CACHE_DATA_W-1:0] rdData,
	output logic hit,
	output logic memRdReq,
	output logic [`CACHE_ADDR_W-1:0] memRdAddr,
	input logic memRdAck,
	input logic [`CACHE_LINE_W-1:0] memRdData,
	output logic memWrReq,
	output logic [`CACHE_ADDR_W-1:0] memWrAddr,
	output logic [`CACHE_LINE_W-1:0] memWrData,
	input logic memWrAck
);

	tagLookup_if lookup ();

	way_t dataWay;
	logic wordWe;
	logic lineWe;
	line_t lineIn;
	line_t lineOut;

	tagStore uTagStore (
		.clk(clk),
		.reset(reset),
		.lookup(lookup)
	);

	dataStore uDataStore (
		.clk(clk),
		.index(addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W]),
		.way(dataWay),
		.wordSel(addr[`CACHE_OFFSET_W-1:0]),
		.wordWe(wordWe),
		.wordIn(wrData),
		.lineWe(lineWe),
		.lineIn(lineIn),
		.wordOut(rdData), // Read data straight from the array
		.lineOut(lineOut)
	);

	cacheController uController (
		.clk(clk),
		.reset(reset),
		.req(req),
		.op(op),
		.addr(addr),
		.wrData(wrData),
		.ack(ack),
		.hit(hit),
		.lookup(lookup),
		.dataWay(dataWay),
		.wordWe(wordWe),
		.lineWe(lineWe),
		.lineIn(lineIn),
		.lineOut(lineOut),
		.memRdReq(memRdReq),
		.memRdAddr(memRdAddr),
		.memRdAck(memRdAck),
		.memRdData(memRdData),
		.memWrReq(memWrReq),
		.memWrAddr(memWrAddr),
		.memWrData(memWrData),
		.memWrAck(memWrAck)
	);

endmodule

// ==== cache_sva.sv ====
`timescale 1ns/100ps
`include "cache_macros.svh"

module cacheSva import cache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic req,
	input cacheOp_t op,
	input logic [`CACHE_ADDR_W-1:0] addr,
	input logic ack,
	input logic memRdReq,
	input logic memWrReq
);

	int failures = 0; // Failed assertion count

	oneMemReq: assert property (@(posedge clk) disable iff (reset) !(memRdReq && memWrReq))
		else begin
			failures++;
			$error("memory read and write requests high together");
		end

	ackNeedsReq: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
		else begin
			failures++;
			$error("ack rose without a pending req");
		end

	// Processor must hold the request until ack
	reqStable: assert property (@(posedge clk) disable iff (reset)
		req && !ack |=> $stable(op) && $stable(addr))
		else begin
			failures++;
			$error("op or addr changed while req waited for ack");
		end

endmodule

bind cacheController cacheSva sva (
	.clk(clk),
	.reset(reset),
	.req(req),
	.op(op),
	.addr(addr),
	.ack(ack),
	.memRdReq(memRdReq),
	.memWrReq(memWrReq)
);

// ==== cacheTb.sv ====
`timescale 1ns/100ps
`include "cache_macros.svh"

module cacheTb import cache_pkg::*; ();

	localparam int ackTimeout = 100;
	localparam logic [`CACHE_DATA_W-1:0] fillPattern = 32'hA5A50000;

	logic clk;
	logic reset;
	logic req;
	cacheOp_t op;
	logic [`CACHE_ADDR_W-1:0] addr;
	logic [`CACHE_DATA_W-1:0] wrData;
	logic ack;
	logic [`CACHE_DATA_W-1:0] rdData;
	logic hit;
	logic memRdReq;
	logic [`CACHE_ADDR_W-1:0] memRdAddr;
	logic memRdAck;
	logic [`CACHE_LINE_W-1:0] memRdData;
	logic memWrReq;
	logic [`CACHE_ADDR_W-1:0] memWrAddr;
	logic [`CACHE_LINE_W-1:0] memWrData;
	logic memWrAck;

	logic [`CACHE_DATA_W-1:0] mem [1 << `CACHE_ADDR_W];
	int rdDelay;
	int wrDelay;
	int lineReads;
	int lineWrites;
	logic [`CACHE_ADDR_W-1:0] lastWrAddr;
	int errorCount;
	int checkCount;
	int ackCycles;
	logic [`CACHE_DATA_W-1:0] gotData;
	logic gotHit;
	logic [`CACHE_DATA_W-1:0] firstWrite;
	logic [`CACHE_DATA_W-1:0] secondWrite;

	cacheTop dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Memory model --------------------

	initial begin
		memRdAck <= 1'b0;
		memWrAck <= 1'b0;
		memRdData <= '0;
		for (int a = 0; a < (1 << `CACHE_ADDR_W); a++) begin
			mem[a] = 32'(a) ^ fillPattern;
		end
		rdDelay = -1; // Not yet drawn
		wrDelay = -1;
		lineReads = 0;
		lineWrites = 0;
		lastWrAddr = '0;
		forever begin
			@(posedge clk);
			if (memRdReq && !memRdAck) begin
				if (rdDelay < 0) rdDelay = int'($urandom % 6);
				if (rdDelay == 0) begin
					for (int w = 0; w < `CACHE_WORDS; w++) begin
						memRdData[w*`CACHE_DATA_W +: `CACHE_DATA_W] <= mem[memRdAddr + 12'(w)];
					end
					memRdAck <= 1'b1;
					lineReads++;
					rdDelay = -1;
				end else begin
					rdDelay--;
				end
			end else if (!memRdReq && memRdAck) begin
				memRdAck <= 1'b0;
			end
			if (memWrReq && !memWrAck) begin
				if (wrDelay < 0) wrDelay = int'($urandom % 6);
				if (wrDelay == 0) begin
					for (int w = 0; w < `CACHE_WORDS; w++) begin
						mem[memWrAddr + 12'(w)] = memWrData[w*`CACHE_DATA_W +: `CACHE_DATA_W];
					end
					memWrAck <= 1'b1;
					lineWrites++;
					lastWrAddr = memWrAddr;
					wrDelay = -1;
				end else begin
					wrDelay--;
				end
			end else if (!memWrReq && memWrAck) begin
				memWrAck <= 1'b0;
			end
		end
	end

	// Helpers --------------------

	function automatic logic [`CACHE_DATA_W-1:0] expectedWord(logic [`CACHE_ADDR_W-1:0] a);
		return {20'h0, a} ^ fillPattern;
	endfunction

	task automatic checkEqual(string name, logic [31:0] got, logic [31:0] expected);
		checkCount++;
		assert (got === expected) else begin
			errorCount++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
		end
	endtask

	// One four-phase processor transaction
	task automatic access(cacheOp_t reqOp, logic [11:0] reqAddr, logic [31:0] reqData);
		int cycles;
		@(posedge clk);
		req <= 1'b1;
		op <= reqOp;
		addr <= reqAddr;
		wrData <= reqData;
		cycles = 0;
		while (ack !== 1'b1 && cycles < ackTimeout) begin
			@(negedge clk);
			cycles++;
		end
		assert (ack === 1'b1) else begin
			errorCount++;
			$display("timed out waiting for ack at address 0x%h", reqAddr);
		end
		ackCycles = cycles;
		gotData = rdData;
		gotHit = hit;
		@(posedge clk);
		req <= 1'b0;
		cycles = 0;
		while (ack !== 1'b0 && cycles < ackTimeout) begin
			@(negedge clk);
			cycles++;
		end
		assert (ack === 1'b0) else begin
			errorCount++;
			$display("ack stayed high after req dropped at address 0x%h", reqAddr);
		end
	endtask

	task automatic expectAccess(cacheOp_t reqOp, logic [11:0] reqAddr, logic [31:0] reqData,
		logic expHit, logic [31:0] expData, int expReads, int expWrites);
		int reads0;
		int writes0;
		reads0 = lineReads;
		writes0 = lineWrites;
		access(reqOp, reqAddr, reqData);
		checkEqual("hit", 32'(gotHit), 32'(expHit));
		if (reqOp != opInvalidate) checkEqual("rdData", gotData, expData);
		checkEqual("lineReads", 32'(lineReads - reads0), 32'(expReads));
		checkEqual("lineWrites", 32'(lineWrites - writes0), 32'(expWrites));
	endtask

	// Tests --------------------

	task automatic readMiss();
		expectAccess(opRead, 12'h040, '0, 1'b0, expectedWord(12'h040), 1, 0);
	endtask

	task automatic readHit();
		for (int w = 0; w < `CACHE_WORDS; w++) begin
			expectAccess(opRead, 12'h040 + 12'(w), '0, 1'b1, expectedWord(12'h040 + 12'(w)), 0, 0);
			checkEqual("ack latency", 32'(ackCycles), 32'd4); // Idle, lookup, update, done
		end
	endtask

	task automatic writeHit();
		expectAccess(opWrite, 12'h041, firstWrite, 1'b1, firstWrite, 0, 0);
		expectAccess(opRead, 12'h041, '0, 1'b1, firstWrite, 0, 0);
	endtask

	// Tags 1, 2 and 3 all map to set 0
	task automatic lruEviction();
		expectAccess(opRead, 12'h080, '0, 1'b0, expectedWord(12'h080), 1, 0);
		expectAccess(opRead, 12'h040, '0, 1'b1, expectedWord(12'h040), 0, 0);
		expectAccess(opRead, 12'h0C0, '0, 1'b0, expectedWord(12'h0C0), 1, 0); // Clean B out
		expectAccess(opRead, 12'h080, '0, 1'b0, expectedWord(12'h080), 1, 1); // Dirty A out
		checkEqual("memWrAddr", 32'(lastWrAddr), 32'h040);
		checkEqual("memWrData", mem[12'h041], firstWrite);
		expectAccess(opRead, 12'h041, '0, 1'b0, firstWrite, 1, 0);
	endtask

	task automatic invalidateLines();
		expectAccess(opWrite, 12'h041, secondWrite, 1'b1, secondWrite, 0, 0);
		expectAccess(opInvalidate, 12'h041, '0, 1'b1, '0, 0, 1);
		checkEqual("memWrAddr", 32'(lastWrAddr), 32'h040);
		checkEqual("memWrData", mem[12'h041], secondWrite);
		expectAccess(opInvalidate, 12'h100, '0, 1'b0, '0, 0, 0);
		expectAccess(opRead, 12'h041, '0, 1'b0, secondWrite, 1, 0);
	endtask

	initial begin
		void'($urandom(32'h1196));
		errorCount = 0;
		checkCount = 0;
		reset <= 1'b1;
		req <= 1'b0;
		op <= opRead;
		addr <= '0;
		wrData <= '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		firstWrite = $urandom;
		secondWrite = $urandom;
		readMiss();
		readHit();
		writeHit();
		lruEviction();
		invalidateLines();
		assert (dut.uController.sva.failures == 0) else begin
			errorCount++;
			$display("protocol assertions failed %0d times", dut.uController.sva.failures);
		end
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
cache_pkg.sv
tagLookup_if.sv
tagStore.sv
dataStore.sv
cacheController.sv
cacheTop.sv
cache_sva.sv
cacheTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module cacheTb \
		-f build.f -Mdir obj_dir
	./obj_dir/VcacheTb +verilator+error+limit+100 | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
